//--- offload_settings.svh
// --------------------------------------
// Width macros for the offload path
// --------------------------------------
`ifndef OFFLOAD_SETTINGS_SVH
`define OFFLOAD_SETTINGS_SVH

// Operand and result word
`define OFFLOAD_DATA_WIDTH 32

// Transaction id carried back with each response
`define OFFLOAD_ID_WIDTH 5

// Divider counter covers the load cycle, 32 steps and the fix-up cycle
`define OFFLOAD_DIV_CNT_WIDTH 6

`endif

//--- offload_pkg.sv
// --------------------------------------
// Offload package with opcode, id, data
// and divider state types
// --------------------------------------
`include "offload_settings.svh"

package offload_pkg;

  // One operand or result word
  typedef logic [`OFFLOAD_DATA_WIDTH-1:0] offload_data_t;

  // Id chosen by the issuing core
  typedef logic [`OFFLOAD_ID_WIDTH-1:0] offload_id_t;

  // Integer opcodes served by the two accelerators
  typedef enum logic [2:0] {
    OP_MUL   = 3'd0,
    OP_MULH  = 3'd1,
    OP_MULHU = 3'd2,
    OP_DIV   = 3'd3,
    OP_DIVU  = 3'd4,
    OP_REM   = 3'd5,
    OP_REMU  = 3'd6
  } offload_op_e;

  // Iterative divider control
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

endpackage

//--- offload_spill_reg.sv
// --------------------------------------
// Two-slot skid buffer on a valid/ready
// stream with optional bypass
// --------------------------------------
`timescale 1ns/100ps

module offload_spill_reg #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    // Plain wires when no cut is wanted
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic             a_full_q;
    logic             b_full_q;
    logic [Width-1:0] a_data_q;
    logic [Width-1:0] b_data_q;
    logic             a_fill;
    logic             a_drain;
    logic             b_fill;
    logic             b_drain;

    // Slot A takes new input
    assign a_fill  = valid_i & ready_o;
    // A empties while B is free, either to the output or into B
    assign a_drain = a_full_q & ~b_full_q;
    // B catches A when the output stalls
    assign b_fill  = a_drain & ~ready_i;
    assign b_drain = b_full_q & ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill | a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill | b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B always holds the older item
    assign valid_o = a_full_q | b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = ~a_full_q | ~b_full_q;
  end

endmodule

//--- offload_dispatch.sv
// --------------------------------------
// Request cut register and opcode based
// steering to multiplier or divider
// --------------------------------------
`timescale 1ns/100ps

module offload_dispatch (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  offload_pkg::offload_op_e   req_op_i,
  input  offload_pkg::offload_id_t   req_id_i,
  input  offload_pkg::offload_data_t req_opa_i,
  input  offload_pkg::offload_data_t req_opb_i,
  // Multiplier request
  output logic                       mul_valid_o,
  input  logic                       mul_ready_i,
  output offload_pkg::offload_op_e   mul_op_o,
  output offload_pkg::offload_id_t   mul_id_o,
  output offload_pkg::offload_data_t mul_opa_o,
  output offload_pkg::offload_data_t mul_opb_o,
  // Divider request
  output logic                       div_valid_o,
  input  logic                       div_ready_i,
  output offload_pkg::offload_op_e   div_op_o,
  output offload_pkg::offload_id_t   div_id_o,
  output offload_pkg::offload_data_t div_opa_o,
  output offload_pkg::offload_data_t div_opb_o
);
  import offload_pkg::*;

  localparam int unsigned OpW   = $bits(offload_op_e);
  localparam int unsigned IdW   = $bits(offload_id_t);
  localparam int unsigned DataW = $bits(offload_data_t);
  localparam int unsigned ReqW  = OpW + IdW + 2 * DataW;

  logic            ready_en_q;
  logic            spill_ready;
  logic            head_valid;
  logic            head_ready;
  logic [ReqW-1:0] head_data;
  offload_op_e     head_op;
  offload_id_t     head_id;
  offload_data_t   head_opa;
  offload_data_t   head_opb;
  logic            head_is_div;

  // Opens the input one cycle after reset release
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
    end
  end

  assign req_ready_o = spill_ready & ready_en_q;

  offload_spill_reg #(
    .Width  ( ReqW ),
    .Bypass ( 1'b0 )
  ) u_req_cut (
    .clk_i   ( clk_i                                          ),
    .rst_i   ( rst_i                                          ),
    .valid_i ( req_valid_i & ready_en_q                       ),
    .ready_o ( spill_ready                                    ),
    .data_i  ( {req_op_i, req_id_i, req_opa_i, req_opb_i}     ),
    .valid_o ( head_valid                                     ),
    .ready_i ( head_ready                                     ),
    .data_o  ( head_data                                      )
  );

  // Unpack the registered request
  assign head_op  = offload_op_e'(head_data[ReqW-1 -: OpW]);
  assign head_id  = head_data[2*DataW +: IdW];
  assign head_opa = head_data[DataW +: DataW];
  assign head_opb = head_data[0 +: DataW];

  // Opcode class picks the target unit
  assign head_is_div = head_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign mul_valid_o = head_valid & ~head_is_div;
  assign div_valid_o = head_valid & head_is_div;
  // Only the addressed unit can stall the head
  assign head_ready  = head_is_div ? div_ready_i : mul_ready_i;

  assign mul_op_o  = head_op;
  assign mul_id_o  = head_id;
  assign mul_opa_o = head_opa;
  assign mul_opb_o = head_opb;
  assign div_op_o  = head_op;
  assign div_id_o  = head_id;
  assign div_opa_o = head_opa;
  assign div_opb_o = head_opb;

endmodule

//--- offload_mul_unit.sv
// --------------------------------------
// Two-stage pipelined 32x32 multiplier
// --------------------------------------
`timescale 1ns/100ps
`include "offload_settings.svh"

module offload_mul_unit (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  offload_pkg::offload_op_e   req_op_i,
  input  offload_pkg::offload_id_t   req_id_i,
  input  offload_pkg::offload_data_t req_opa_i,
  input  offload_pkg::offload_data_t req_opb_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output offload_pkg::offload_id_t   resp_id_o,
  output offload_pkg::offload_data_t resp_data_o
);
  import offload_pkg::*;

  localparam int unsigned DW = `OFFLOAD_DATA_WIDTH;

  logic            advance;
  logic            mulh_signed;
  logic [2*DW-1:0] full_prod;
  // Stage one holds the full product
  logic            s1_valid_q;
  offload_id_t     s1_id_q;
  logic [2*DW-1:0] s1_prod_q;
  logic            s1_high_q;
  // Stage two holds the selected word
  logic            s2_valid_q;
  offload_id_t     s2_id_q;
  offload_data_t   s2_data_q;

  // Whole pipe moves only when the output slot is free or leaving
  assign advance     = ~s2_valid_q | resp_ready_i;
  assign req_ready_o = advance;

  // MUL low word is sign agnostic so only MULH extends the sign
  assign mulh_signed = (req_op_i == OP_MULH);
  assign full_prod   = $signed({mulh_signed & req_opa_i[DW-1], req_opa_i})
                     * $signed({mulh_signed & req_opb_i[DW-1], req_opb_i});

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= req_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_id_q   <= req_id_i;
      s1_prod_q <= full_prod;
      s1_high_q <= (req_op_i != OP_MUL);
      s2_id_q   <= s1_id_q;
      s2_data_q <= s1_high_q ? s1_prod_q[2*DW-1:DW] : s1_prod_q[DW-1:0];
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_id_o    = s2_id_q;
  assign resp_data_o  = s2_data_q;

endmodule

//--- offload_div_unit.sv
// --------------------------------------
// Iterative radix-2 divider with RISC-V
// zero and overflow results
// --------------------------------------
`timescale 1ns/100ps
`include "offload_settings.svh"

module offload_div_unit (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  offload_pkg::offload_op_e   req_op_i,
  input  offload_pkg::offload_id_t   req_id_i,
  input  offload_pkg::offload_data_t req_opa_i,
  input  offload_pkg::offload_data_t req_opb_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output offload_pkg::offload_id_t   resp_id_o,
  output offload_pkg::offload_data_t resp_data_o
);
  import offload_pkg::*;

  localparam int unsigned   DW     = `OFFLOAD_DATA_WIDTH;
  localparam int unsigned   CW     = `OFFLOAD_DIV_CNT_WIDTH;
  // Count 0 loads, 1 to DW iterate, DW+1 fixes up
  localparam logic [CW-1:0] CntFix = CW'(DW + 1);

  div_state_e    state_q;
  logic [CW-1:0] cnt_q;
  offload_op_e   op_q;
  offload_id_t   id_q;
  offload_data_t opa_q;
  offload_data_t opb_q;
  offload_data_t quo_q;
  offload_data_t rem_q;
  offload_data_t dsr_q;
  offload_data_t res_q;
  logic          is_signed;
  logic          is_rem;
  logic          neg_a;
  logic          neg_b;
  logic          div_zero;
  logic          overflow;
  logic [DW:0]   rem_shift;
  logic          sub_ok;
  offload_data_t quo_fix;
  offload_data_t rem_fix;

  // ------------------------------------
  // Operand classes
  // ------------------------------------
  assign is_signed = op_q inside {OP_DIV, OP_REM};
  assign is_rem    = op_q inside {OP_REM, OP_REMU};
  assign neg_a     = is_signed & opa_q[DW-1];
  assign neg_b     = is_signed & opb_q[DW-1];
  assign div_zero  = (opb_q == '0);
  // Most negative value divided by minus one
  assign overflow  = is_signed & (opa_q == {1'b1, {(DW-1){1'b0}}}) & (opb_q == '1);

  // Shift in the next dividend bit and try the subtraction
  assign rem_shift = {rem_q, quo_q[DW-1]};
  assign sub_ok    = (rem_shift >= {1'b0, dsr_q});
  // Quotient sign from both operands, remainder follows the dividend
  assign quo_fix   = (neg_a ^ neg_b) ? -quo_q : quo_q;
  assign rem_fix   = neg_a ? -rem_q : rem_q;

  // ------------------------------------
  // Control FSM
  // ------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          cnt_q <= '0;
          if (req_valid_i) begin
            state_q <= DIV_RUN;
          end
        end
        DIV_RUN: begin
          cnt_q <= cnt_q + CW'(1);
          if (cnt_q == CntFix) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (resp_ready_i) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // ------------------------------------
  // Datapath
  // ------------------------------------
  always_ff @(posedge clk_i) begin
    if ((state_q == DIV_IDLE) && req_valid_i) begin
      op_q  <= req_op_i;
      id_q  <= req_id_i;
      opa_q <= req_opa_i;
      opb_q <= req_opb_i;
    end else if (state_q == DIV_RUN) begin
      if (cnt_q == '0) begin
        // Load magnitudes
        quo_q <= neg_a ? -opa_q : opa_q;
        dsr_q <= neg_b ? -opb_q : opb_q;
        rem_q <= '0;
      end else if (cnt_q == CntFix) begin
        if (div_zero) begin
          res_q <= is_rem ? opa_q : '1;
        end else if (overflow) begin
          res_q <= is_rem ? '0 : opa_q;
        end else begin
          res_q <= is_rem ? rem_fix : quo_fix;
        end
      end else begin
        // True difference is below 2^DW so the low bits suffice
        rem_q <= sub_ok ? rem_shift[DW-1:0] - dsr_q : rem_shift[DW-1:0];
        quo_q <= {quo_q[DW-2:0], sub_ok};
      end
    end
  end

  assign req_ready_o  = (state_q == DIV_IDLE);
  assign resp_valid_o = (state_q == DIV_DONE);
  assign resp_id_o    = id_q;
  assign resp_data_o  = res_q;

endmodule

//--- offload_resp_merge.sv
// --------------------------------------
// Round-robin merge of unit responses
// and response cut register
// --------------------------------------
`timescale 1ns/100ps

module offload_resp_merge (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       mul_valid_i,
  output logic                       mul_ready_o,
  input  offload_pkg::offload_id_t   mul_id_i,
  input  offload_pkg::offload_data_t mul_data_i,
  input  logic                       div_valid_i,
  output logic                       div_ready_o,
  input  offload_pkg::offload_id_t   div_id_i,
  input  offload_pkg::offload_data_t div_data_i,
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output offload_pkg::offload_id_t   resp_id_o,
  output offload_pkg::offload_data_t resp_data_o
);
  import offload_pkg::*;

  localparam int unsigned RespW = $bits(offload_id_t) + $bits(offload_data_t);

  logic             prio_div_q;
  logic             grant_div;
  logic             arb_valid;
  logic             arb_ready;
  logic [RespW-1:0] arb_data;
  logic [RespW-1:0] out_data;

  // Divider wins when alone or when it holds priority
  assign grant_div   = div_valid_i & (~mul_valid_i | prio_div_q);
  assign arb_valid   = mul_valid_i | div_valid_i;
  assign arb_data    = grant_div ? {div_id_i, div_data_i} : {mul_id_i, mul_data_i};
  assign mul_ready_o = arb_ready & ~grant_div;
  assign div_ready_o = arb_ready & grant_div;

  // Priority moves to the unit that lost
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      prio_div_q <= 1'b0;
    end else if (arb_valid & arb_ready) begin
      prio_div_q <= ~grant_div;
    end
  end

  offload_spill_reg #(
    .Width  ( RespW ),
    .Bypass ( 1'b0  )
  ) u_resp_cut (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .valid_i ( arb_valid    ),
    .ready_o ( arb_ready    ),
    .data_i  ( arb_data     ),
    .valid_o ( resp_valid_o ),
    .ready_i ( resp_ready_i ),
    .data_o  ( out_data     )
  );

  assign {resp_id_o, resp_data_o} = out_data;

endmodule

//--- offload_cc.sv
// --------------------------------------
// Offload top: dispatch, multiplier,
// divider and response merge
// --------------------------------------
`timescale 1ns/100ps

module offload_cc (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Request from the issuing core
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  offload_pkg::offload_op_e   req_op_i,
  input  offload_pkg::offload_id_t   req_id_i,
  input  offload_pkg::offload_data_t req_opa_i,
  input  offload_pkg::offload_data_t req_opb_i,
  // Response to the core
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output offload_pkg::offload_id_t   resp_id_o,
  output offload_pkg::offload_data_t resp_data_o
);
  import offload_pkg::*;

  // Multiplier streams
  logic          mul_req_valid;
  logic          mul_req_ready;
  offload_op_e   mul_req_op;
  offload_id_t   mul_req_id;
  offload_data_t mul_req_opa;
  offload_data_t mul_req_opb;
  logic          mul_resp_valid;
  logic          mul_resp_ready;
  offload_id_t   mul_resp_id;
  offload_data_t mul_resp_data;
  // Divider streams
  logic          div_req_valid;
  logic          div_req_ready;
  offload_op_e   div_req_op;
  offload_id_t   div_req_id;
  offload_data_t div_req_opa;
  offload_data_t div_req_opb;
  logic          div_resp_valid;
  logic          div_resp_ready;
  offload_id_t   div_resp_id;
  offload_data_t div_resp_data;

  offload_dispatch u_dispatch (
    .clk_i       ( clk_i         ),
    .rst_i       ( rst_i         ),
    .req_valid_i ( req_valid_i   ),
    .req_ready_o ( req_ready_o   ),
    .req_op_i    ( req_op_i      ),
    .req_id_i    ( req_id_i      ),
    .req_opa_i   ( req_opa_i     ),
    .req_opb_i   ( req_opb_i     ),
    .mul_valid_o ( mul_req_valid ),
    .mul_ready_i ( mul_req_ready ),
    .mul_op_o    ( mul_req_op    ),
    .mul_id_o    ( mul_req_id    ),
    .mul_opa_o   ( mul_req_opa   ),
    .mul_opb_o   ( mul_req_opb   ),
    .div_valid_o ( div_req_valid ),
    .div_ready_i ( div_req_ready ),
    .div_op_o    ( div_req_op    ),
    .div_id_o    ( div_req_id    ),
    .div_opa_o   ( div_req_opa   ),
    .div_opb_o   ( div_req_opb   )
  );

  offload_mul_unit u_mul (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .req_valid_i  ( mul_req_valid  ),
    .req_ready_o  ( mul_req_ready  ),
    .req_op_i     ( mul_req_op     ),
    .req_id_i     ( mul_req_id     ),
    .req_opa_i    ( mul_req_opa    ),
    .req_opb_i    ( mul_req_opb    ),
    .resp_valid_o ( mul_resp_valid ),
    .resp_ready_i ( mul_resp_ready ),
    .resp_id_o    ( mul_resp_id    ),
    .resp_data_o  ( mul_resp_data  )
  );

  offload_div_unit u_div (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .req_valid_i  ( div_req_valid  ),
    .req_ready_o  ( div_req_ready  ),
    .req_op_i     ( div_req_op     ),
    .req_id_i     ( div_req_id     ),
    .req_opa_i    ( div_req_opa    ),
    .req_opb_i    ( div_req_opb    ),
    .resp_valid_o ( div_resp_valid ),
    .resp_ready_i ( div_resp_ready ),
    .resp_id_o    ( div_resp_id    ),
    .resp_data_o  ( div_resp_data  )
  );

  offload_resp_merge u_merge (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .mul_valid_i  ( mul_resp_valid ),
    .mul_ready_o  ( mul_resp_ready ),
    .mul_id_i     ( mul_resp_id    ),
    .mul_data_i   ( mul_resp_data  ),
    .div_valid_i  ( div_resp_valid ),
    .div_ready_o  ( div_resp_ready ),
    .div_id_i     ( div_resp_id    ),
    .div_data_i   ( div_resp_data  ),
    .resp_valid_o ( resp_valid_o   ),
    .resp_ready_i ( resp_ready_i   ),
    .resp_id_o    ( resp_id_o      ),
    .resp_data_o  ( resp_data_o    )
  );

endmodule

//--- tb_clock_gen.sv
// --------------------------------------
// Testbench clock and reset source
// --------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held over three rising edges, released just after the third
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

//--- tb_offload_cc.sv
// --------------------------------------
// Directed tests for the offload path
// with scoreboard and reference model
// --------------------------------------
`timescale 1ns/100ps

module tb_offload_cc;
  import offload_pkg::*;

  localparam int unsigned NumIds  = 1 << $bits(offload_id_t);
  localparam int unsigned Timeout = 1000;
  localparam int unsigned Seed    = 32'h815f_c476;

  logic          clk;
  logic          rst;
  logic          req_valid;
  logic          req_ready;
  offload_op_e   req_op;
  offload_id_t   req_id;
  offload_data_t req_opa;
  offload_data_t req_opb;
  logic          resp_valid;
  logic          resp_ready;
  offload_id_t   resp_id;
  offload_data_t resp_data;

  // Scoreboard indexed by id
  bit            pending [NumIds];
  bit            is_mul [NumIds];
  offload_data_t exp_data [NumIds];
  offload_id_t   mul_order [$];
  offload_id_t   next_id;
  int            outstanding;
  int            checks;
  int            errors;
  string         cur_test;
  bit            release_on_stall;
  bit            stall_seen;
  offload_op_e   mul_ops [$];
  offload_op_e   div_ops [$];

  tb_clock_gen u_clk (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  offload_cc u_dut (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .req_valid_i  ( req_valid  ),
    .req_ready_o  ( req_ready  ),
    .req_op_i     ( req_op     ),
    .req_id_i     ( req_id     ),
    .req_opa_i    ( req_opa    ),
    .req_opb_i    ( req_opb    ),
    .resp_valid_o ( resp_valid ),
    .resp_ready_i ( resp_ready ),
    .resp_id_o    ( resp_id    ),
    .resp_data_o  ( resp_data  )
  );

  // --------------------------------------
  // Reference model and reporting
  // --------------------------------------
  function automatic offload_data_t ref_result(input offload_op_e op, input offload_data_t a,
                                               input offload_data_t b);
    logic signed [63:0] sprod;
    logic [63:0]        uprod;
    logic signed [31:0] sq;
    logic signed [31:0] sr;
    logic               ovf;
    offload_data_t      res;
    sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    uprod = {32'd0, a} * {32'd0, b};
    // Most negative value over minus one
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    sq = '0;
    sr = '0;
    if ((b != '0) && !ovf) begin
      sq = $signed(a) / $signed(b);
      sr = $signed(a) % $signed(b);
    end
    case (op)
      OP_MUL:   res = uprod[31:0];
      OP_MULH:  res = sprod[63:32];
      OP_MULHU: res = uprod[63:32];
      OP_DIV:   res = (b == '0) ? 32'hffff_ffff : (ovf ? a : sq);
      OP_DIVU:  res = (b == '0) ? 32'hffff_ffff : a / b;
      OP_REM:   res = (b == '0) ? a : (ovf ? 32'd0 : sr);
      OP_REMU:  res = (b == '0) ? a : a % b;
      default:  res = '0;
    endcase
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout in %s: %s", cur_test, msg);
    errors++;
    finish_run();
  endtask

  // --------------------------------------
  // Stimulus helpers
  // --------------------------------------
  // Presents one request and holds it until accepted
  task automatic send_req(input offload_op_e op, input offload_data_t a, input offload_data_t b);
    int unsigned cycles;
    bit          taken;
    cycles = 0;
    // Id can be reused only after its response came back
    while (pending[next_id]) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > Timeout) report_timeout("an id never returned and cannot be reused");
    end
    exp_data[next_id] = ref_result(op, a, b);
    is_mul[next_id]   = op inside {OP_MUL, OP_MULH, OP_MULHU};
    pending[next_id]  = 1'b1;
    outstanding++;
    if (is_mul[next_id]) begin
      mul_order.push_back(next_id);
    end
    req_valid = 1'b1;
    req_op    = op;
    req_id    = next_id;
    req_opa   = a;
    req_opb   = b;
    taken     = 1'b0;
    cycles    = 0;
    while (!taken) begin
      // Ready seen at the falling edge means a transfer at the next rising one
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #1;
      if (!taken) begin
        cycles++;
        // Back-pressure test lets the port go once the input stalls
        if (release_on_stall && !resp_ready) begin
          stall_seen = 1'b1;
          resp_ready = 1'b1;
        end
        if (cycles > Timeout) report_timeout("request was never accepted");
      end
    end
    req_valid = 1'b0;
    next_id   = next_id + offload_id_t'(1);
  endtask

  task automatic wait_drain();
    int unsigned cycles;
    cycles = 0;
    while (outstanding != 0) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > Timeout) begin
        report_timeout($sformatf("%0d responses never came back", outstanding));
      end
    end
  endtask

  // Response monitor sampling at the falling edge where outputs are settled
  always @(negedge clk) begin
    if (!rst && resp_valid && resp_ready) begin
      if (!pending[resp_id]) begin
        $display("Response with id %0d in %s has no outstanding request", resp_id, cur_test);
        errors++;
      end else begin
        check_value($sformatf("%s id %0d", cur_test, resp_id), exp_data[resp_id], resp_data);
        pending[resp_id] = 1'b0;
        outstanding--;
        // Oldest issued multiplier id must come back first
        if (is_mul[resp_id]) begin
          check_value($sformatf("%s mul order", cur_test), 32'(mul_order[0]), 32'(resp_id));
          void'(mul_order.pop_front());
        end
      end
    end
  end

  // --------------------------------------
  // Directed tests
  // --------------------------------------
  task automatic test_reset();
    int unsigned cycles;
    cur_test = "test_reset";
    cycles   = 0;
    do begin
      @(negedge clk);
      check_value(cur_test, 32'd0, 32'(resp_valid));
      if (rst) begin
        check_value(cur_test, 32'd0, 32'(req_ready));
      end
      cycles++;
      if (cycles > Timeout) report_timeout("reset was never released");
    end while (rst);
    cycles = 0;
    // Input opens shortly after release with nothing on the output
    while (!req_ready) begin
      @(negedge clk);
      check_value(cur_test, 32'd0, 32'(resp_valid));
      cycles++;
      if (cycles > Timeout) report_timeout("req_ready_o stayed low after reset");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_mul();
    offload_data_t ca [$];
    offload_data_t cb [$];
    cur_test = "test_mul";
    ca = {32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
          32'h8000_0000, 32'h7fff_ffff, 32'h7fff_ffff, 32'h1234_5678};
    cb = {32'h0000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000,
          32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'h9abc_def0};
    foreach (ca[i]) begin
      foreach (mul_ops[k]) begin
        send_req(mul_ops[k], ca[i], cb[i]);
      end
    end
    for (int i = 0; i < 20; i++) begin
      send_req(mul_ops[$urandom_range(2, 0)], $urandom(), $urandom());
    end
    wait_drain();
  endtask

  task automatic test_div();
    offload_data_t ca [$];
    offload_data_t cb [$];
    cur_test = "test_div";
    // Sign mixes, zero divisor and signed overflow
    ca = {32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c, 32'h1234_5678,
          32'd0, 32'h8000_0000, 32'h8000_0000, 32'hffff_ffff};
    cb = {32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9, 32'd0,
          32'd0, 32'hffff_ffff, 32'd1, 32'hffff_ffff};
    foreach (ca[i]) begin
      foreach (div_ops[k]) begin
        send_req(div_ops[k], ca[i], cb[i]);
      end
    end
    // Shifted divisors give a spread of quotient sizes
    for (int i = 0; i < 12; i++) begin
      send_req(div_ops[$urandom_range(3, 0)], $urandom(), $urandom() >> $urandom_range(31, 0));
    end
    wait_drain();
  endtask

  task automatic test_mixed_order();
    cur_test = "test_mixed_order";
    // Multiplier results overtake the slow divider
    for (int i = 0; i < 24; i++) begin
      if ((i % 2) == 0) begin
        send_req(div_ops[$urandom_range(3, 0)], $urandom(), $urandom() >> $urandom_range(31, 0));
      end else begin
        send_req(mul_ops[$urandom_range(2, 0)], $urandom(), $urandom());
      end
    end
    wait_drain();
  endtask

  task automatic test_backpressure();
    cur_test         = "test_backpressure";
    stall_seen       = 1'b0;
    release_on_stall = 1'b1;
    resp_ready       = 1'b0;
    // Multiplier requests only so that a stall comes from the full pipeline
    for (int i = 0; i < 24; i++) begin
      send_req(mul_ops[$urandom_range(2, 0)], $urandom(), $urandom());
    end
    release_on_stall = 1'b0;
    if (!stall_seen) begin
      $display("req_ready_o never dropped while resp_ready_i was held low");
      errors++;
    end
    resp_ready = 1'b1;
    wait_drain();
  endtask

  initial begin
    void'($urandom(Seed));
    req_valid        = 1'b0;
    req_op           = OP_MUL;
    req_id           = '0;
    req_opa          = '0;
    req_opb          = '0;
    resp_ready       = 1'b1;
    next_id          = '0;
    outstanding      = 0;
    checks           = 0;
    errors           = 0;
    release_on_stall = 1'b0;
    stall_seen       = 1'b0;
    mul_ops          = {OP_MUL, OP_MULH, OP_MULHU};
    div_ops          = {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    test_reset();
    test_mul();
    test_div();
    test_mixed_order();
    test_backpressure();
    finish_run();
  end

endmodule

//--- verilog.f
+incdir+.
offload_pkg.sv
offload_spill_reg.sv
offload_dispatch.sv
offload_mul_unit.sv
offload_div_unit.sv
offload_resp_merge.sv
offload_cc.sv
tb_clock_gen.sv
tb_offload_cc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the offload testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module tb_offload_cc -f verilog.f -o tb_offload_cc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_offload_cc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench prints its verdict into the log
if grep -q "test failed" "$LOG"; then
  exit 1
fi
exit 0
